// File: include/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// register and bus widths
`define CSR_DATA_W      32
`define CSR_NUM_W       14

// exception cause fields in ESTAT
`define ECODE_W         6
`define ESUBCODE_W      9

// interrupt lines
// IS[1:0] software, IS[9:2] hardware, IS[10] reserved, IS[11] timer, IS[12] IPI
`define HW_INT_W        8
`define INT_W           13

// counter stops here once a one-shot countdown passes zero
`define TIMER_IDLE      32'hffff_ffff

`define STABLE_CNT_W    64

`endif

// File: src/csr_pkg.sv
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    // implemented CSR numbers, anything else reads zero
    typedef enum logic [`CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h0,
        CSR_PRMD   = 14'h1,
        CSR_ECFG   = 14'h4,
        CSR_ESTAT  = 14'h5,
        CSR_ERA    = 14'h6,
        CSR_BADV   = 14'h7,
        CSR_EENTRY = 14'hc,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_num_e;

    // only the codes that load BADV are decoded here
    typedef enum logic [`ECODE_W-1:0] {
        ECODE_ADE = 6'h8,
        ECODE_ALE = 6'h9
    } ecode_e;

endpackage

`default_nettype wire

// File: src/csr_exc_regs.sv
`default_nettype none

`include "csr_config.svh"

module csr_exc_regs
    import csr_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_num_e           csr_num,
    input  wire                     csr_we,
    input  wire [`CSR_DATA_W-1:0]   csr_wmask,
    input  wire [`CSR_DATA_W-1:0]   csr_wvalue,
    input  wire                     wb_ex,
    input  wire [`ECODE_W-1:0]      wb_ecode,
    input  wire [`ESUBCODE_W-1:0]   wb_esubcode,
    input  wire [`CSR_DATA_W-1:0]   wb_pc,
    input  wire [`CSR_DATA_W-1:0]   wb_vaddr,
    input  wire                     ertn_flush,
    input  wire [`INT_W-1:0]        int_status,
    output logic                    crmd_ie,
    output logic [`CSR_DATA_W-1:0]  csr_eentry,
    output logic [`CSR_DATA_W-1:0]  rdata
);

    logic [1:0]                 crmd_plv;
    logic [1:0]                 prmd_pplv;
    logic                       prmd_pie;
    logic [`ECODE_W-1:0]        estat_ecode;
    logic [`ESUBCODE_W-1:0]     estat_esubcode;
    logic [`CSR_DATA_W-1:0]     era;
    logic [`CSR_DATA_W-1:0]     badv;
    logic [25:0]                eentry_va;
    logic                       is_ade_fetch;
    logic                       is_ale;

    // ADE with subcode 0 is a fetch address error, so the faulting address is the PC
    assign is_ade_fetch = (wb_ecode == ECODE_ADE) && (wb_esubcode == '0);
    assign is_ale       = (wb_ecode == ECODE_ALE);

    // exception entry first, then return, then software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= (csr_wmask[1:0] & csr_wvalue[1:0]) | (~csr_wmask[1:0] & crmd_plv);
            crmd_ie  <= (csr_wmask[2] & csr_wvalue[2]) | (~csr_wmask[2] & crmd_ie);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= (csr_wmask[1:0] & csr_wvalue[1:0]) | (~csr_wmask[1:0] & prmd_pplv);
            prmd_pie  <= (csr_wmask[2] & csr_wvalue[2]) | (~csr_wmask[2] & prmd_pie);
        end
    end

    // cause, return address and faulting address
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era            <= wb_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era <= (csr_wmask & csr_wvalue) | (~csr_wmask & era);
        end

        if (wb_ex && is_ade_fetch) begin
            badv <= wb_pc;
        end else if (wb_ex && is_ale) begin
            badv <= wb_vaddr;
        end
    end

    // entry vector is 64-byte aligned
    always_ff @(posedge clk) begin
        if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= (csr_wmask[31:6] & csr_wvalue[31:6]) | (~csr_wmask[31:6] & eentry_va);
        end
    end

    assign csr_eentry = {eentry_va, 6'b0};

    always_comb begin
        case (csr_num)
            CSR_CRMD:   rdata = {28'b0, 1'b1, crmd_ie, crmd_plv};
            CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            // IS[10] is reserved
            CSR_ESTAT:  rdata = {1'b0, estat_esubcode, estat_ecode, 3'b0,
                                 int_status[12:11], 1'b0, int_status[9:0]};
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = csr_eentry;
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_int_ctrl.sv
`default_nettype none

`include "csr_config.svh"

module csr_int_ctrl
    import csr_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_num_e           csr_num,
    input  wire                     csr_we,
    input  wire [`CSR_DATA_W-1:0]   csr_wmask,
    input  wire [`CSR_DATA_W-1:0]   csr_wvalue,
    input  wire [`HW_INT_W-1:0]     hw_int_in,
    input  wire                     ipi_int_in,
    input  wire                     timer_int,
    input  wire                     crmd_ie,
    output logic [`INT_W-1:0]       int_status,
    output logic                    has_int,
    output logic [`CSR_DATA_W-1:0]  rdata
);

    // bit 10 of the local enable is reserved
    localparam logic [`INT_W-1:0] LIE_MASK = 13'h1bff;

    logic [`INT_W-1:0]      ecfg_lie;
    logic [1:0]             swi;
    logic [`HW_INT_W-1:0]   hw_int_q;
    logic                   ipi_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            swi      <= 2'b0;
            hw_int_q <= '0;
            ipi_q    <= 1'b0;
        end else begin
            if (csr_we && csr_num == CSR_ECFG) begin
                ecfg_lie <= ((csr_wmask[`INT_W-1:0] & csr_wvalue[`INT_W-1:0])
                          | (~csr_wmask[`INT_W-1:0] & ecfg_lie)) & LIE_MASK;
            end
            // software interrupts are the only writable ESTAT.IS bits
            if (csr_we && csr_num == CSR_ESTAT) begin
                swi <= (csr_wmask[1:0] & csr_wvalue[1:0]) | (~csr_wmask[1:0] & swi);
            end
            hw_int_q <= hw_int_in;
            ipi_q    <= ipi_int_in;
        end
    end

    assign int_status = {ipi_q, timer_int, 1'b0, hw_int_q, swi};

    // IPI is not part of the enable reduction
    assign has_int = (|(int_status[11:0] & ecfg_lie[11:0])) && crmd_ie;

    assign rdata = (csr_num == CSR_ECFG) ? {{(`CSR_DATA_W-`INT_W){1'b0}}, ecfg_lie} : '0;

endmodule

`default_nettype wire

// File: src/csr_timer.sv
`default_nettype none

`include "csr_config.svh"

module csr_timer
    import csr_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_num_e           csr_num,
    input  wire                     csr_we,
    input  wire [`CSR_DATA_W-1:0]   csr_wmask,
    input  wire [`CSR_DATA_W-1:0]   csr_wvalue,
    output logic                    timer_int,
    output logic [`CSR_DATA_W-1:0]  rdata
);

    logic                       tcfg_en;
    logic                       tcfg_periodic;
    logic [29:0]                tcfg_initval;
    logic [`CSR_DATA_W-1:0]     tcfg_word;
    logic [`CSR_DATA_W-1:0]     tcfg_next;
    logic [`CSR_DATA_W-1:0]     timer_cnt;
    logic                       tcfg_wr;
    logic                       ticlr_wr;

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_wr   = csr_we && (csr_num == CSR_TCFG);
    assign ticlr_wr  = csr_we && (csr_num == CSR_TICLR) && csr_wmask[0] && csr_wvalue[0];

    // merged TCFG value, so a write that enables the timer loads it at once
    assign tcfg_next = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_word);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_en <= tcfg_next[0];
        end
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // one-shot mode runs 0 -> all ones and then holds
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // a new expiry beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_wr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (csr_num)
            CSR_TCFG: rdata = tcfg_word;
            CSR_TVAL: rdata = timer_cnt;
            // TICLR reads zero like every unowned number
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_misc_regs.sv
`default_nettype none

`include "csr_config.svh"

module csr_misc_regs
    import csr_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_num_e               csr_num,
    input  wire                         csr_we,
    input  wire [`CSR_DATA_W-1:0]       csr_wmask,
    input  wire [`CSR_DATA_W-1:0]       csr_wvalue,
    input  wire [`CSR_DATA_W-1:0]       coreid_in,
    output logic [`STABLE_CNT_W-1:0]    stable_counter_value,
    output logic [`CSR_DATA_W-1:0]      rdata
);

    logic [`CSR_DATA_W-1:0]     save [0:3];
    logic [`CSR_DATA_W-1:0]     tid;
    logic [`CSR_NUM_W-1:0]      num_bits;
    logic                       is_save;

    // SAVE0..3 sit on consecutive numbers, low two bits pick the entry
    assign num_bits = csr_num;
    assign is_save  = (csr_num >= CSR_SAVE0) && (csr_num <= CSR_SAVE3);

    always_ff @(posedge clk) begin
        if (csr_we && is_save) begin
            save[num_bits[1:0]] <= (csr_wmask & csr_wvalue)
                                 | (~csr_wmask & save[num_bits[1:0]]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= coreid_in;
        end else if (csr_we && csr_num == CSR_TID) begin
            tid <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_counter_value <= '0;
        end else begin
            stable_counter_value <= stable_counter_value + 1'b1;
        end
    end

    always_comb begin
        if (is_save) begin
            rdata = save[num_bits[1:0]];
        end else if (csr_num == CSR_TID) begin
            rdata = tid;
        end else begin
            rdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/csr_file.sv
`default_nettype none

`include "csr_config.svh"

module csr_file
    import csr_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         csr_re,
    input  wire csr_num_e               csr_num,
    input  wire                         csr_we,
    input  wire [`CSR_DATA_W-1:0]       csr_wmask,
    input  wire [`CSR_DATA_W-1:0]       csr_wvalue,
    input  wire                         wb_ex,
    input  wire [`ECODE_W-1:0]          wb_ecode,
    input  wire [`ESUBCODE_W-1:0]       wb_esubcode,
    input  wire [`CSR_DATA_W-1:0]       wb_pc,
    input  wire [`CSR_DATA_W-1:0]       wb_vaddr,
    input  wire                         ertn_flush,
    input  wire [`CSR_DATA_W-1:0]       coreid_in,
    input  wire [`HW_INT_W-1:0]         hw_int_in,
    input  wire                         ipi_int_in,
    output logic [`CSR_DATA_W-1:0]      csr_rvalue,
    output logic [`CSR_DATA_W-1:0]      csr_eentry,
    output logic                        has_int,
    output logic [`STABLE_CNT_W-1:0]    stable_counter_value
);

    logic [`CSR_DATA_W-1:0]     rdata_exc;
    logic [`CSR_DATA_W-1:0]     rdata_int;
    logic [`CSR_DATA_W-1:0]     rdata_tmr;
    logic [`CSR_DATA_W-1:0]     rdata_misc;
    logic                       crmd_ie;
    logic                       timer_int;
    logic [`INT_W-1:0]          int_status;

    csr_exc_regs u_exc_regs (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .int_status  (int_status),
        .crmd_ie     (crmd_ie),
        .csr_eentry  (csr_eentry),
        .rdata       (rdata_exc)
    );

    csr_int_ctrl u_int_ctrl (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_int  (timer_int),
        .crmd_ie    (crmd_ie),
        .int_status (int_status),
        .has_int    (has_int),
        .rdata      (rdata_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .timer_int  (timer_int),
        .rdata      (rdata_tmr)
    );

    csr_misc_regs u_misc_regs (
        .clk                  (clk),
        .reset                (reset),
        .csr_num              (csr_num),
        .csr_we               (csr_we),
        .csr_wmask            (csr_wmask),
        .csr_wvalue           (csr_wvalue),
        .coreid_in            (coreid_in),
        .stable_counter_value (stable_counter_value),
        .rdata                (rdata_misc)
    );

    // groups return zero for numbers they do not own
    assign csr_rvalue = (rdata_exc | rdata_int | rdata_tmr | rdata_misc) & {`CSR_DATA_W{csr_re}};

endmodule

`default_nettype wire

// File: verif/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// shadow copies of the architectural state
logic [1:0]                 m_plv;
logic                       m_ie;
logic [1:0]                 m_pplv;
logic                       m_pie;
logic [`ECODE_W-1:0]        m_ecode;
logic [`ESUBCODE_W-1:0]     m_esub;
logic [`CSR_DATA_W-1:0]     m_era;
logic [`CSR_DATA_W-1:0]     m_badv;
logic [`CSR_DATA_W-1:0]     m_eentry;
logic [`INT_W-1:0]          m_ecfg;
logic [1:0]                 m_swi;
logic [`HW_INT_W-1:0]       m_hw;
logic                       m_ipi;
logic [`CSR_DATA_W-1:0]     m_tcfg;
logic [`CSR_DATA_W-1:0]     m_tval;
logic                       m_tint;
logic [`CSR_DATA_W-1:0]     m_save [0:3];
logic [`CSR_DATA_W-1:0]     m_tid;

function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] mask,
                                      input logic [31:0] value);
    return (old & ~mask) | (value & mask);
endfunction

// IS field: ipi, timer, reserved, hardware lines, software bits
function automatic logic [12:0] interrupt_status();
    return {m_ipi, m_tint, 1'b0, m_hw, m_swi};
endfunction

function automatic logic expected_has_int();
    return m_ie && ((interrupt_status() & m_ecfg & 13'h0fff) != 13'd0);
endfunction

function automatic logic [31:0] expected_read(input logic [13:0] num);
    logic [31:0] r;
    case (num)
        CSR_CRMD:   r = {28'd0, 1'b1, m_ie, m_plv};
        CSR_PRMD:   r = {29'd0, m_pie, m_pplv};
        CSR_ECFG:   r = {19'd0, m_ecfg};
        CSR_ESTAT:  r = ({23'd0, m_esub} << 22) | ({26'd0, m_ecode} << 16)
                      | {19'd0, interrupt_status()};
        CSR_ERA:    r = m_era;
        CSR_BADV:   r = m_badv;
        CSR_EENTRY: r = m_eentry & 32'hffff_ffc0;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    r = m_save[num[1:0]];
        CSR_TID:    r = m_tid;
        CSR_TCFG:   r = m_tcfg;
        CSR_TVAL:   r = m_tval;
        default:    r = 32'd0;
    endcase
    return r;
endfunction

// one clock edge of the register rules, from the inputs held during the cycle
task automatic update_model();
    logic [13:0] num;
    logic [31:0] cfg;
    logic [31:0] w;
    logic        wr;
    logic        fire;
    logic        ticlr;
    num = csr_num;
    wr  = csr_we;
    if (reset) begin
        m_plv     = 2'd0;
        m_ie      = 1'b0;
        m_ecfg    = '0;
        m_swi     = 2'd0;
        m_hw      = '0;
        m_ipi     = 1'b0;
        m_tcfg[0] = 1'b0;
        m_tval    = `TIMER_IDLE;
        m_tint    = 1'b0;
        m_tid     = coreid_in;
    end else begin
        // timer works from the configuration held before this edge
        fire  = m_tcfg[0] && (m_tval == 32'd0);
        ticlr = wr && num == CSR_TICLR && csr_wmask[0] && csr_wvalue[0];
        cfg   = merge(m_tcfg, csr_wmask, csr_wvalue);
        if (wr && num == CSR_TCFG && cfg[0]) begin
            m_tval = {cfg[31:2], 2'b00};
        end else if (m_tcfg[0] && m_tval != `TIMER_IDLE) begin
            if (m_tval == 32'd0 && m_tcfg[1]) begin
                m_tval = {m_tcfg[31:2], 2'b00};
            end else begin
                m_tval = m_tval - 32'd1;
            end
        end
        if (fire) begin
            m_tint = 1'b1;
        end else if (ticlr) begin
            m_tint = 1'b0;
        end
        if (wr && num == CSR_TCFG) begin
            m_tcfg = cfg;
        end

        if (wb_ex) begin
            m_pplv  = m_plv;
            m_pie   = m_ie;
            m_plv   = 2'd0;
            m_ie    = 1'b0;
            m_ecode = wb_ecode;
            m_esub  = wb_esubcode;
            m_era   = wb_pc;
            if (wb_ecode == ECODE_ADE && wb_esubcode == '0) begin
                m_badv = wb_pc;
            end else if (wb_ecode == ECODE_ALE) begin
                m_badv = wb_vaddr;
            end
        end else begin
            if (ertn_flush) begin
                m_plv = m_pplv;
                m_ie  = m_pie;
            end else if (wr && num == CSR_CRMD) begin
                w     = merge({29'd0, m_ie, m_plv}, csr_wmask, csr_wvalue);
                m_plv = w[1:0];
                m_ie  = w[2];
            end
            if (wr && num == CSR_PRMD) begin
                w      = merge({29'd0, m_pie, m_pplv}, csr_wmask, csr_wvalue);
                m_pplv = w[1:0];
                m_pie  = w[2];
            end
            if (wr && num == CSR_ERA) begin
                m_era = merge(m_era, csr_wmask, csr_wvalue);
            end
        end

        if (wr && num == CSR_EENTRY) begin
            m_eentry = merge(m_eentry, csr_wmask, csr_wvalue) & 32'hffff_ffc0;
        end
        if (wr && num == CSR_ECFG) begin
            w      = merge({19'd0, m_ecfg}, csr_wmask, csr_wvalue);
            m_ecfg = w[12:0] & 13'h1bff;
        end
        if (wr && num == CSR_ESTAT) begin
            w     = merge({30'd0, m_swi}, csr_wmask, csr_wvalue);
            m_swi = w[1:0];
        end
        if (wr && num >= CSR_SAVE0 && num <= CSR_SAVE3) begin
            m_save[num[1:0]] = merge(m_save[num[1:0]], csr_wmask, csr_wvalue);
        end
        if (wr && num == CSR_TID) begin
            m_tid = merge(m_tid, csr_wmask, csr_wvalue);
        end
        m_hw  = hw_int_in;
        m_ipi = ipi_int_in;
    end
endtask

`endif

// File: verif/csr_file_tb.sv
`default_nettype none

`include "csr_config.svh"

module csr_file_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 10;
    // reset, init and the five test phases, rounded up
    localparam int TOTAL_CYCLES = 1500;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           csr_re;
    csr_num_e                       csr_num;
    logic                           csr_we;
    logic [`CSR_DATA_W-1:0]         csr_wmask;
    logic [`CSR_DATA_W-1:0]         csr_wvalue;
    logic                           wb_ex;
    logic [`ECODE_W-1:0]            wb_ecode;
    logic [`ESUBCODE_W-1:0]         wb_esubcode;
    logic [`CSR_DATA_W-1:0]         wb_pc;
    logic [`CSR_DATA_W-1:0]         wb_vaddr;
    logic                           ertn_flush;
    logic [`CSR_DATA_W-1:0]         coreid_in;
    logic [`HW_INT_W-1:0]           hw_int_in;
    logic                           ipi_int_in;
    logic [`CSR_DATA_W-1:0]         csr_rvalue;
    logic [`CSR_DATA_W-1:0]         csr_eentry;
    logic                           has_int;
    logic [`STABLE_CNT_W-1:0]       stable_counter_value;

    integer                         seed = 82480;
    integer                         errors = 0;
    logic                           check_en = 1'b0;

    csr_num_e rw_nums  [0:7] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                 CSR_ERA, CSR_EENTRY, CSR_ECFG, CSR_TID};
    csr_num_e exc_nums [0:4] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV};

    `include "csr_ref_model.svh"

    csr_file uut (
        .clk                  (clk),
        .reset                (reset),
        .csr_re               (csr_re),
        .csr_num              (csr_num),
        .csr_we               (csr_we),
        .csr_wmask            (csr_wmask),
        .csr_wvalue           (csr_wvalue),
        .wb_ex                (wb_ex),
        .wb_ecode             (wb_ecode),
        .wb_esubcode          (wb_esubcode),
        .wb_pc                (wb_pc),
        .wb_vaddr             (wb_vaddr),
        .ertn_flush           (ertn_flush),
        .coreid_in            (coreid_in),
        .hw_int_in            (hw_int_in),
        .ipi_int_in           (ipi_int_in),
        .csr_rvalue           (csr_rvalue),
        .csr_eentry           (csr_eentry),
        .has_int              (has_int),
        .stable_counter_value (stable_counter_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input csr_num_e num, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        next_cycle();
        csr_we = 1'b0;
    endtask

    // value is taken at the falling edge, where the read path has settled
    task automatic read_csr(input csr_num_e num, output logic [31:0] value);
        csr_re  = 1'b1;
        csr_num = num;
        @(negedge clk);
        value = csr_rvalue;
        next_cycle();
        csr_re = 1'b0;
    endtask

    // model advances on every edge
    always @(posedge clk) begin
        update_model();
    end

    always @(negedge clk) begin
        if (check_en) begin
            check_value(csr_rvalue, csr_re ? expected_read(csr_num) : 32'd0,
                        $sformatf("csr_rvalue for CSR 0x%0h", csr_num));
            check_value(has_int, expected_has_int(), "has_int");
            check_value(csr_eentry, m_eentry & 32'hffff_ffc0, "csr_eentry");
        end
    end

    initial begin
        #(20 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", 20 * TOTAL_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0]    rd;
        logic [13:0]    rnum;
        logic [63:0]    s1;
        int             i;
        int             j;
        int             n;
        reset       = 1'b1;
        csr_re      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        coreid_in   = random_word();
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // unreset registers get known values before checking starts
        wb_ex    = 1'b1;
        wb_ecode = ECODE_ALE;
        wb_pc    = random_word();
        wb_vaddr = random_word();
        next_cycle();
        wb_ex = 1'b0;
        write_csr(CSR_EENTRY, 32'hffff_ffff, random_word());
        for (i = 0; i < 4; i++) begin
            write_csr(rw_nums[i], 32'hffff_ffff, random_word());
        end
        write_csr(CSR_TCFG, 32'hffff_ffff, random_word() & 32'hffff_fffe);
        check_en = 1'b1;
        read_csr(CSR_TID, rd);
        check_value(rd, coreid_in, "TID after reset");

        // masked writes, readback and reads of arbitrary numbers
        for (i = 0; i < 200; i++) begin
            write_csr(rw_nums[random_word() % 8], random_word(), random_word());
            read_csr(csr_num, rd);
            rnum    = random_word();
            csr_num = (i % 2) ? csr_num_e'(rnum) : rw_nums[random_word() % 8];
            csr_re  = random_word() & 1;
            next_cycle();
            csr_re = 1'b0;
        end

        // exception entry and return, with priority collisions
        for (i = 0; i < 40; i++) begin
            write_csr(CSR_CRMD, 32'h7, random_word());
            n = random_word() % 3;
            wb_ecode    = (n == 0) ? ECODE_ADE : (n == 1) ? ECODE_ALE : random_word();
            wb_esubcode = (random_word() & 1) ? '0 : random_word();
            wb_pc       = random_word();
            wb_vaddr    = random_word();
            wb_ex       = 1'b1;
            ertn_flush  = random_word() & 1;
            csr_we      = random_word() & 1;
            csr_num     = CSR_CRMD;
            csr_wmask   = 32'h7;
            csr_wvalue  = random_word();
            next_cycle();
            wb_ex      = 1'b0;
            ertn_flush = 1'b0;
            csr_we     = 1'b0;
            for (j = 0; j < 5; j++) begin
                read_csr(exc_nums[j], rd);
            end
            ertn_flush = 1'b1;
            next_cycle();
            ertn_flush = 1'b0;
            read_csr(CSR_CRMD, rd);
        end

        // interrupt collection and has_int
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h1fff);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        for (i = 0; i < 150; i++) begin
            hw_int_in  = random_word();
            ipi_int_in = random_word() & 1;
            if (i % 4 == 0) begin
                write_csr(CSR_ESTAT, 32'h3, random_word());
            end else if (i % 7 == 0) begin
                write_csr(CSR_ECFG, random_word(), random_word());
            end else begin
                read_csr(CSR_ESTAT, rd);
            end
        end
        hw_int_in  = '0;
        ipi_int_in = 1'b0;
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h800);

        // one-shot timer, initial value 5
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h15);
        read_csr(CSR_TVAL, rd);
        check_value(rd, 32'd20, "TVAL after load");
        for (n = 1; n <= 20; n++) begin
            read_csr(CSR_TVAL, rd);
            check_value(rd, 32'd20 - n, "TVAL countdown");
        end
        read_csr(CSR_ESTAT, rd);
        check_value(rd[11], 1'b1, "ESTAT timer bit one cycle after TVAL reached zero");
        read_csr(CSR_TVAL, rd);
        check_value(rd, `TIMER_IDLE, "TVAL after one-shot expiry");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, rd);
        check_value(rd[11], 1'b0, "ESTAT timer bit after TICLR");
        read_csr(CSR_TICLR, rd);
        check_value(rd, 32'd0, "TICLR read");

        // periodic timer with clears along the way
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0f);
        for (i = 0; i < 60; i++) begin
            if (i % 16 == 15) begin
                write_csr(CSR_TICLR, 32'h1, 32'h1);
            end else begin
                read_csr((i % 3) ? CSR_TVAL : CSR_ESTAT, rd);
            end
        end
        write_csr(CSR_TCFG, 32'h1, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);

        // stable counter steps once per cycle
        for (i = 0; i < 5; i++) begin
            n = 1 + (random_word() % 40);
            @(negedge clk);
            s1 = stable_counter_value;
            repeat (n) @(negedge clk);
            check_value(stable_counter_value - s1, n, "stable counter difference");
        end
        next_cycle();

        $display("summary: %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_file.f
+incdir+include
+incdir+verif
src/csr_pkg.sv
src/csr_exc_regs.sv
src/csr_int_ctrl.sv
src/csr_timer.sv
src/csr_misc_regs.sv
src/csr_file.sv
verif/csr_file_tb.sv
